//--- ecc_lite_defs.svh
// ----------------------------------------
// ecc_lite shared widths and constants
// for the modular exponentiation engine
// ----------------------------------------
`ifndef ECC_LITE_DEFS_SVH
`define ECC_LITE_DEFS_SVH

// operand word width
`define WORD_W   16

// group modulus and the fixed keygen base
`define PRIME    16'd65521
`define GEN      16'd17

// operand memory, 4 words
`define MEM_AW   2

// microcode rom address
`define PROG_AW  3

// one multiplier iteration per multiplier bit
`define MULT_CYC `WORD_W

`endif

//--- ecc_lite_pkg.sv
// ----------------------------------------
// ecc_lite enum types shared across blocks
// ----------------------------------------
`default_nettype none

package ecc_lite_pkg;

    // host commands
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_KEYGEN,
        CMD_EXP
    } cmd_e;

    // sequencer micro-ops
    typedef enum logic [2:0] {
        UOP_NOP,
        UOP_SET_ONE,
        UOP_SQR,
        UOP_MULB,
        UOP_NEXT,
        UOP_END
    } uop_e;

    // engine control states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_RD_A,
        ST_RD_B,
        ST_MULT,
        ST_WR,
        ST_DONE
    } fsm_state_e;

    // operand memory map
    typedef enum logic [1:0] {
        ADDR_BASE,
        ADDR_ACC,
        ADDR_SCRATCH
    } mem_addr_e;

endpackage

`default_nettype wire

//--- dsa_sequencer_rom.sv
// ----------------------------------------
// microcode ROM for the exponent loop
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module dsa_sequencer_rom (
    input  wire [`PROG_AW-1:0] prog_addr_i,
    output ecc_lite_pkg::uop_e prog_uop_o
);
    import ecc_lite_pkg::*;

    // program layout
    //   0 acc = 1
    //   1 acc = acc * acc
    //   2 acc = acc * base if bit set
    //   3 loop to 1 while bits remain
    //   4 read out acc
    always_comb begin
        unique case (prog_addr_i)
            `PROG_AW'd0: prog_uop_o = UOP_SET_ONE;
            `PROG_AW'd1: prog_uop_o = UOP_SQR;
            `PROG_AW'd2: prog_uop_o = UOP_MULB;
            `PROG_AW'd3: prog_uop_o = UOP_NEXT;
            `PROG_AW'd4: prog_uop_o = UOP_END;
            default:     prog_uop_o = UOP_NOP;
        endcase
    end

endmodule

`default_nettype wire

//--- mod_mult.sv
// ----------------------------------------
// bit-serial modular multiplier
// interleaved MSB-first shift-add mod PRIME
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module mod_mult (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                zeroize_i,
    input  wire                start_i,
    input  wire [`WORD_W-1:0]  a_i,
    input  wire [`WORD_W-1:0]  b_i,
    output logic               busy_o,
    output logic [`WORD_W-1:0] result_o
);
    localparam int CNT_W = $clog2(`MULT_CYC);

    logic [`WORD_W-1:0] a_q;
    logic [`WORD_W-1:0] b_q;
    logic [CNT_W-1:0]   cnt;
    logic [`WORD_W:0]   dbl;
    logic [`WORD_W:0]   dbl_red;
    logic [`WORD_W:0]   sum;
    logic [`WORD_W:0]   sum_red;

    // one step: r = 2r + bit*a, each term kept below PRIME
    // a is below PRIME, so one subtraction per term is enough
    always_comb begin
        dbl     = {result_o, 1'b0};
        dbl_red = (dbl >= `PRIME) ? dbl - `PRIME : dbl;
        sum     = dbl_red + (b_q[`WORD_W-1] ? a_q : '0);
        sum_red = (sum >= `PRIME) ? sum - `PRIME : sum;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o   <= 1'b0;
            cnt      <= '0;
            a_q      <= '0;
            b_q      <= '0;
            result_o <= '0;
        end else if (zeroize_i) begin
            busy_o   <= 1'b0;
            cnt      <= '0;
            a_q      <= '0;
            b_q      <= '0;
            result_o <= '0;
        end else if (start_i) begin
            busy_o   <= 1'b1;
            cnt      <= '0;
            a_q      <= a_i;
            b_q      <= b_i;
            result_o <= '0;
        end else if (busy_o) begin
            result_o <= sum_red[`WORD_W-1:0];
            b_q      <= b_q << 1;
            cnt      <= cnt + 1'b1;
            if (cnt == CNT_W'(`MULT_CYC - 1))
                busy_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- operand_ram_arb.sv
// ----------------------------------------
// operand RAM with host-first arbiter
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module operand_ram_arb (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize_i,
    input  wire                           h_req_i,
    input  wire                           h_we_i,
    input  wire ecc_lite_pkg::mem_addr_e  h_addr_i,
    input  wire [`WORD_W-1:0]             h_wdata_i,
    output logic                          h_gnt_o,
    input  wire                           e_req_i,
    input  wire                           e_we_i,
    input  wire ecc_lite_pkg::mem_addr_e  e_addr_i,
    input  wire [`WORD_W-1:0]             e_wdata_i,
    output logic                          e_gnt_o,
    output logic [`WORD_W-1:0]            rdata_o
);
    logic [`WORD_W-1:0] mem [0:(1<<`MEM_AW)-1];
    logic               we;
    logic               re;
    logic [`MEM_AW-1:0] addr;
    logic [`WORD_W-1:0] wdata;

    // fixed priority, the engine waits while the host holds the port
    assign h_gnt_o = h_req_i;
    assign e_gnt_o = e_req_i & ~h_req_i;

    assign we    = (h_gnt_o & h_we_i) | (e_gnt_o & e_we_i);
    assign re    = (h_gnt_o & ~h_we_i) | (e_gnt_o & ~e_we_i);
    assign addr  = h_gnt_o ? h_addr_i : e_addr_i;
    assign wdata = h_gnt_o ? h_wdata_i : e_wdata_i;

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < (1 << `MEM_AW); i++)
                mem[i] <= '0;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read data one cycle after the grant, held until the next read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            rdata_o <= '0;
        else if (zeroize_i)
            rdata_o <= '0;
        else if (re)
            rdata_o <= mem[addr];
    end

    // a stalled engine request stays up, unchanged, until it is granted
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
                     (e_req_i && !e_gnt_o) |=>
                     (e_req_i && $stable(e_we_i) && $stable(e_addr_i)));

endmodule

`default_nettype wire

//--- host_regs.sv
// ----------------------------------------
// host register block
// command latch, range checks, base load
// and result/status capture
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module host_regs (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize_i,
    input  wire                        start_i,
    input  wire ecc_lite_pkg::cmd_e    cmd_i,
    input  wire [`WORD_W-1:0]          k_i,
    input  wire [`WORD_W-1:0]          x_i,
    input  wire                        busy_i,
    input  wire                        fin_i,
    input  wire [`WORD_W-1:0]          fin_data_i,
    output logic                       go_o,
    output logic [`WORD_W-1:0]         k_o,
    output logic                       ready_o,
    output logic                       valid_o,
    output logic                       done_o,
    output logic                       error_o,
    output logic [`WORD_W-1:0]         result_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output ecc_lite_pkg::mem_addr_e    mem_addr_o,
    output logic [`WORD_W-1:0]         mem_wdata_o,
    input  wire                        mem_gnt_i
);
    import ecc_lite_pkg::*;

    logic               ready_q;
    logic               load_q;
    cmd_e               cmd_q;
    logic [`WORD_W-1:0] k_q;
    logic [`WORD_W-1:0] x_q;
    logic               accept;
    logic               range_err;

    assign ready_o = ready_q & ~busy_i;
    assign accept  = start_i & ready_o & (cmd_i != CMD_NONE);

    // checked on the raw inputs in the start cycle
    always_comb begin
        range_err = 1'b0;
        if (cmd_i == CMD_KEYGEN)
            range_err = (k_i == '0) || (k_i >= `PRIME - 1'b1);
        else if (cmd_i == CMD_EXP)
            range_err = (x_i == '0) || (x_i >= `PRIME);
    end

    // base load, keygen always uses the generator
    assign mem_req_o   = load_q;
    assign mem_we_o    = 1'b1;
    assign mem_addr_o  = ADDR_BASE;
    assign mem_wdata_o = (cmd_q == CMD_KEYGEN) ? `GEN : x_q;
    assign go_o        = load_q & mem_gnt_i;
    assign k_o         = k_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_q  <= 1'b1;
            load_q   <= 1'b0;
            cmd_q    <= CMD_NONE;
            k_q      <= '0;
            x_q      <= '0;
            valid_o  <= 1'b0;
            done_o   <= 1'b0;
            error_o  <= 1'b0;
            result_o <= '0;
        end else if (zeroize_i) begin
            ready_q  <= 1'b1;
            load_q   <= 1'b0;
            cmd_q    <= CMD_NONE;
            k_q      <= '0;
            x_q      <= '0;
            valid_o  <= 1'b0;
            done_o   <= 1'b0;
            error_o  <= 1'b0;
            result_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (accept) begin
                // a failed check leaves the block ready
                ready_q <= range_err;
                load_q  <= ~range_err;
                error_o <= range_err;
                valid_o <= 1'b0;
                cmd_q   <= cmd_i;
                k_q     <= k_i;
                x_q     <= x_i;
            end
            if (go_o)
                load_q <= 1'b0;
            if (fin_i) begin
                result_o <= fin_data_i;
                valid_o  <= 1'b1;
                done_o   <= 1'b1;
                ready_q  <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) done_o |=> !done_o);

endmodule

`default_nettype wire

//--- dsa_ctrl_fsm.sv
// ----------------------------------------
// engine control FSM
// walks the microcode, reads operands,
// drives the multiplier and writes ACC
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module dsa_ctrl_fsm (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       zeroize_i,
    input  wire                       go_i,
    input  wire [`WORD_W-1:0]         k_i,
    input  wire ecc_lite_pkg::uop_e   prog_uop_i,
    input  wire                       mult_busy_i,
    input  wire [`WORD_W-1:0]         mult_result_i,
    input  wire                       mem_gnt_i,
    input  wire [`WORD_W-1:0]         mem_rdata_i,
    output logic                      busy_o,
    output logic [`PROG_AW-1:0]       prog_addr_o,
    output logic                      mult_start_o,
    output logic [`WORD_W-1:0]        mult_a_o,
    output logic [`WORD_W-1:0]        mult_b_o,
    output logic                      fin_o,
    output logic [`WORD_W-1:0]        fin_data_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output ecc_lite_pkg::mem_addr_e   mem_addr_o,
    output logic [`WORD_W-1:0]        mem_wdata_o
);
    import ecc_lite_pkg::*;

    localparam int BIT_W = $clog2(`WORD_W);
    // slot of UOP_SQR, target of the loop jump
    localparam logic [`PROG_AW-1:0] LOOP_PC = 1;

    fsm_state_e          state;
    logic [`PROG_AW-1:0] pc;
    logic [BIT_W-1:0]    bit_idx;
    logic [`WORD_W-1:0]  k_q;
    logic [`WORD_W-1:0]  a_q;
    logic                mult_sent;

    assign busy_o      = (state != ST_IDLE);
    assign prog_addr_o = pc;

    // memory requests, second operand is BASE only for MULB
    assign mem_req_o   = (state == ST_RD_A) || (state == ST_RD_B) || (state == ST_WR);
    assign mem_we_o    = (state == ST_WR);
    assign mem_addr_o  = ((state == ST_RD_B) && (prog_uop_i == UOP_MULB)) ? ADDR_BASE : ADDR_ACC;
    assign mem_wdata_o = (prog_uop_i == UOP_SET_ONE) ? {{(`WORD_W-1){1'b0}}, 1'b1}
                                                     : mult_result_i;

    // operand b arrives from memory in the first MULT cycle
    assign mult_start_o = (state == ST_MULT) && !mult_sent;
    assign mult_a_o     = a_q;
    assign mult_b_o     = mem_rdata_i;
    assign fin_o        = (state == ST_DONE);
    assign fin_data_o   = mem_rdata_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            pc        <= '0;
            bit_idx   <= '0;
            k_q       <= '0;
            a_q       <= '0;
            mult_sent <= 1'b0;
        end else if (zeroize_i) begin
            state     <= ST_IDLE;
            pc        <= '0;
            bit_idx   <= '0;
            k_q       <= '0;
            a_q       <= '0;
            mult_sent <= 1'b0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (go_i) begin
                        k_q     <= k_i;
                        pc      <= '0;
                        bit_idx <= BIT_W'(`WORD_W - 1);
                        state   <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    unique case (prog_uop_i)
                        UOP_SET_ONE: state <= ST_WR;
                        UOP_SQR:     state <= ST_RD_A;
                        UOP_END:     state <= ST_RD_A;
                        UOP_MULB: begin
                            // zero bit skips the multiply
                            if (k_q[bit_idx])
                                state <= ST_RD_A;
                            else
                                pc <= pc + 1'b1;
                        end
                        UOP_NEXT: begin
                            if (bit_idx != '0) begin
                                bit_idx <= bit_idx - 1'b1;
                                pc      <= LOOP_PC;
                            end else begin
                                pc <= pc + 1'b1;
                            end
                        end
                        default: pc <= pc + 1'b1;
                    endcase
                end
                ST_RD_A: begin
                    if (mem_gnt_i)
                        state <= (prog_uop_i == UOP_END) ? ST_DONE : ST_RD_B;
                end
                ST_RD_B: begin
                    // read data holds operand a until the next granted read
                    a_q <= mem_rdata_i;
                    if (mem_gnt_i)
                        state <= ST_MULT;
                end
                ST_MULT: begin
                    if (!mult_sent) begin
                        mult_sent <= 1'b1;
                    end else if (!mult_busy_i) begin
                        mult_sent <= 1'b0;
                        state     <= ST_WR;
                    end
                end
                ST_WR: begin
                    if (mem_gnt_i) begin
                        pc    <= pc + 1'b1;
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the multiplier is never restarted while it is still running
    assert property (@(posedge clk) disable iff (!reset_n) mult_start_o |-> !mult_busy_i);

endmodule

`default_nettype wire

//--- ecc_lite_top.sv
// ----------------------------------------
// ecc_lite top level
// square-and-multiply mod PRIME with a
// microcoded engine and shared operand RAM
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module ecc_lite_top (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     zeroize_i,
    input  wire                     start_i,
    input  wire ecc_lite_pkg::cmd_e cmd_i,
    input  wire [`WORD_W-1:0]       k_i,
    input  wire [`WORD_W-1:0]       x_i,
    output logic                    ready_o,
    output logic                    valid_o,
    output logic                    done_o,
    output logic                    error_o,
    output logic [`WORD_W-1:0]      result_o
);
    import ecc_lite_pkg::*;

    // host to engine handoff
    logic                go;
    logic [`WORD_W-1:0]  k_eng;
    logic                eng_busy;
    logic                fin;
    logic [`WORD_W-1:0]  fin_data;

    // memory ports
    logic                h_req;
    logic                h_we;
    mem_addr_e           h_addr;
    logic [`WORD_W-1:0]  h_wdata;
    logic                h_gnt;
    logic                e_req;
    logic                e_we;
    mem_addr_e           e_addr;
    logic [`WORD_W-1:0]  e_wdata;
    logic                e_gnt;
    logic [`WORD_W-1:0]  rdata;

    // sequencer and multiplier
    logic [`PROG_AW-1:0] prog_addr;
    uop_e                prog_uop;
    logic                mult_start;
    logic [`WORD_W-1:0]  mult_a;
    logic [`WORD_W-1:0]  mult_b;
    logic                mult_busy;
    logic [`WORD_W-1:0]  mult_result;

    host_regs host_regs_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .cmd_i       (cmd_i),
        .k_i         (k_i),
        .x_i         (x_i),
        .busy_i      (eng_busy),
        .fin_i       (fin),
        .fin_data_i  (fin_data),
        .go_o        (go),
        .k_o         (k_eng),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .done_o      (done_o),
        .error_o     (error_o),
        .result_o    (result_o),
        .mem_req_o   (h_req),
        .mem_we_o    (h_we),
        .mem_addr_o  (h_addr),
        .mem_wdata_o (h_wdata),
        .mem_gnt_i   (h_gnt)
    );

    dsa_ctrl_fsm dsa_ctrl_fsm_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .go_i          (go),
        .k_i           (k_eng),
        .prog_uop_i    (prog_uop),
        .mult_busy_i   (mult_busy),
        .mult_result_i (mult_result),
        .mem_gnt_i     (e_gnt),
        .mem_rdata_i   (rdata),
        .busy_o        (eng_busy),
        .prog_addr_o   (prog_addr),
        .mult_start_o  (mult_start),
        .mult_a_o      (mult_a),
        .mult_b_o      (mult_b),
        .fin_o         (fin),
        .fin_data_o    (fin_data),
        .mem_req_o     (e_req),
        .mem_we_o      (e_we),
        .mem_addr_o    (e_addr),
        .mem_wdata_o   (e_wdata)
    );

    dsa_sequencer_rom dsa_sequencer_rom_inst (
        .prog_addr_i (prog_addr),
        .prog_uop_o  (prog_uop)
    );

    mod_mult mod_mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (mult_start),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .busy_o    (mult_busy),
        .result_o  (mult_result)
    );

    operand_ram_arb operand_ram_arb_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .h_req_i   (h_req),
        .h_we_i    (h_we),
        .h_addr_i  (h_addr),
        .h_wdata_i (h_wdata),
        .h_gnt_o   (h_gnt),
        .e_req_i   (e_req),
        .e_we_i    (e_we),
        .e_addr_i  (e_addr),
        .e_wdata_i (e_wdata),
        .e_gnt_o   (e_gnt),
        .rdata_o   (rdata)
    );

endmodule

`default_nettype wire

//--- tb_ecc_lite.sv
// ----------------------------------------
// testbench for ecc_lite_top
// random EXP and KEYGEN commands checked
// against a square-and-multiply model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ecc_lite_defs.svh"

module tb_ecc_lite;
    import ecc_lite_pkg::*;

    localparam int TIMEOUT_CYC = 2000;
    localparam int P           = `PRIME;

    logic               clk;
    logic               reset_n;
    logic               zeroize_i;
    logic               start_i;
    cmd_e               cmd_i;
    logic [`WORD_W-1:0] k_i;
    logic [`WORD_W-1:0] x_i;
    logic               ready_o;
    logic               valid_o;
    logic               done_o;
    logic               error_o;
    logic [`WORD_W-1:0] result_o;

    integer seed;

    ecc_lite_top ecc_lite_top_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (start_i),
        .cmd_i     (cmd_i),
        .k_i       (k_i),
        .x_i       (x_i),
        .ready_o   (ready_o),
        .valid_o   (valid_o),
        .done_o    (done_o),
        .error_o   (error_o),
        .result_o  (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // reference model and helpers
    // ----------------------------------------

    // right-to-left binary exponentiation mod PRIME
    function automatic longint unsigned mod_exp(input longint unsigned base,
                                                input longint unsigned e);
        longint unsigned acc;
        longint unsigned b;
        longint unsigned rem;
        acc = 1;
        b   = base % P;
        rem = e;
        while (rem != 0) begin
            if (rem[0])
                acc = (acc * b) % P;
            b   = (b * b) % P;
            rem = rem >> 1;
        end
        return acc;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string what, input longint got, input longint exp);
        assert (got == exp)
        else stop_on_failure($sformatf("ERROR at %0t: %s is %0d, expected %0d",
                                       $time, what, got, exp));
    endtask

    // one-cycle start strobe, driven just after the edge
    task automatic issue_start(input cmd_e cmd, input logic [`WORD_W-1:0] k,
                               input logic [`WORD_W-1:0] x);
        @(posedge clk);
        #2;
        start_i = 1'b1;
        cmd_i   = cmd;
        k_i     = k;
        x_i     = x;
        @(posedge clk);
        #2;
        start_i = 1'b0;
    endtask

    // one-cycle zeroize pulse, returns at the following falling edge
    task automatic pulse_zeroize();
        @(posedge clk);
        #2;
        zeroize_i = 1'b1;
        @(posedge clk);
        #2;
        zeroize_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_for_end(input string what);
        int cycles;
        cycles = 0;
        while (!(done_o || error_o) && cycles < TIMEOUT_CYC) begin
            @(negedge clk);
            cycles++;
        end
        if (!(done_o || error_o))
            stop_on_failure($sformatf("timeout: %s saw neither done nor error in %0d cycles",
                                      what, TIMEOUT_CYC));
    endtask

    task automatic check_done(input longint unsigned exp, input string what);
        wait_for_end(what);
        check_equal({what, " done_o"}, done_o, 1);
        check_equal({what, " error_o"}, error_o, 0);
        check_equal({what, " result_o"}, result_o, exp);
        check_equal({what, " valid_o"}, valid_o, 1);
        check_equal({what, " ready_o at done"}, ready_o, 1);
        // done is a single-cycle pulse
        @(negedge clk);
        check_equal({what, " done_o one cycle later"}, done_o, 0);
    endtask

    task automatic check_range_error(input cmd_e cmd, input logic [`WORD_W-1:0] k,
                                     input logic [`WORD_W-1:0] x, input string what);
        issue_start(cmd, k, x);
        wait_for_end(what);
        check_equal({what, " error_o"}, error_o, 1);
        check_equal({what, " done_o"}, done_o, 0);
        check_equal({what, " valid_o"}, valid_o, 0);
        check_equal({what, " ready_o"}, ready_o, 1);
        repeat (8) begin
            @(negedge clk);
            check_equal({what, " done_o after error"}, done_o, 0);
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        logic [`WORD_W-1:0] k;
        logic [`WORD_W-1:0] x;
        logic [`WORD_W-1:0] k2;
        logic [`WORD_W-1:0] x2;

        seed      = 32'hc1f1;
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        start_i   = 1'b0;
        cmd_i     = CMD_NONE;
        k_i       = '0;
        x_i       = '0;

        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;
        @(negedge clk);
        check_equal("reset ready_o", ready_o, 1);
        check_equal("reset valid_o", valid_o, 0);
        check_equal("reset done_o", done_o, 0);
        check_equal("reset error_o", error_o, 0);
        check_equal("reset result_o", result_o, 0);

        // x in 1..P-1, any k
        repeat (40) begin
            x = `WORD_W'(($unsigned($random(seed)) % (P - 1)) + 1);
            k = `WORD_W'($random(seed));
            issue_start(CMD_EXP, k, x);
            check_equal("EXP ready_o after start", ready_o, 0);
            check_done(mod_exp(x, k), "EXP");
        end

        // k in 1..P-2, x is ignored by keygen
        repeat (20) begin
            k = `WORD_W'(($unsigned($random(seed)) % (P - 2)) + 1);
            x = `WORD_W'($random(seed));
            issue_start(CMD_KEYGEN, k, x);
            check_equal("KEYGEN ready_o after start", ready_o, 0);
            check_done(mod_exp(`GEN, k), "KEYGEN");
        end

        check_range_error(CMD_KEYGEN, '0, 16'd5, "KEYGEN k=0");
        check_range_error(CMD_KEYGEN, `WORD_W'(P - 1), 16'd5, "KEYGEN k=P-1");
        check_range_error(CMD_EXP, 16'd77, '0, "EXP x=0");
        x = `WORD_W'(P + ($unsigned($random(seed)) % 15));
        check_range_error(CMD_EXP, 16'd77, x, "EXP x>=P");

        // second start while busy must not disturb the first command
        x  = `WORD_W'(($unsigned($random(seed)) % (P - 1)) + 1);
        k  = `WORD_W'($random(seed));
        x2 = `WORD_W'(($unsigned($random(seed)) % (P - 1)) + 1);
        k2 = `WORD_W'(($unsigned($random(seed)) % (P - 2)) + 1);
        issue_start(CMD_EXP, k, x);
        check_equal("busy ready_o", ready_o, 0);
        start_i = 1'b1;
        cmd_i   = CMD_KEYGEN;
        k_i     = k2;
        x_i     = x2;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        check_done(mod_exp(x, k), "EXP with ignored start");

        // zeroize part way through a command
        x = `WORD_W'(($unsigned($random(seed)) % (P - 1)) + 1);
        k = 16'hffff;
        issue_start(CMD_EXP, k, x);
        repeat (50) @(posedge clk);
        pulse_zeroize();
        check_equal("zeroize valid_o", valid_o, 0);
        check_equal("zeroize result_o", result_o, 0);
        check_equal("zeroize ready_o", ready_o, 1);
        check_equal("zeroize done_o", done_o, 0);
        repeat (1000) begin
            @(negedge clk);
            check_equal("done_o after zeroize", done_o, 0);
        end

        x = `WORD_W'(($unsigned($random(seed)) % (P - 1)) + 1);
        k = `WORD_W'($random(seed));
        issue_start(CMD_EXP, k, x);
        check_done(mod_exp(x, k), "EXP after zeroize");

        // zeroize with a finished result still on the outputs
        check_equal("valid_o before idle zeroize", valid_o, 1);
        pulse_zeroize();
        check_equal("idle zeroize valid_o", valid_o, 0);
        check_equal("idle zeroize result_o", result_o, 0);
        check_equal("idle zeroize ready_o", ready_o, 1);
        check_equal("idle zeroize done_o", done_o, 0);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- ecc_lite.f
+incdir+.
ecc_lite_pkg.sv
dsa_sequencer_rom.sv
mod_mult.sv
operand_ram_arb.sv
host_regs.sv
dsa_ctrl_fsm.sv
ecc_lite_top.sv
tb_ecc_lite.sv

//--- Bender.yml
package:
  name: ecc_lite

sources:
  - include_dirs:
      - .
    files:
      - ecc_lite_pkg.sv
      - dsa_sequencer_rom.sv
      - mod_mult.sv
      - operand_ram_arb.sv
      - host_regs.sv
      - dsa_ctrl_fsm.sv
      - ecc_lite_top.sv
      - target: test
        files:
          - tb_ecc_lite.sv
